// File: build.sh
#!/bin/bash
# compile and run the tile cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module memTileCacheTb \
	-f memTileCache.f -o memTileCacheSim
if [ $? -ne 0 ]; then
	echo "build.sh: compile failed"
	exit 1
fi

simOut=$(./obj_dir/memTileCacheSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "build.sh: simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
exit 1

// File: dv/memTileCacheTb.sv
`timescale 1ns/1ps

module memTileCacheTb;

	localparam int tileIdxBits = 7;
	// same index, next tag
	localparam logic [47:0] tagStride = 48'(1) << (tileIdxBits + 6);
	// access bounds per test, tests 2 to 4 run again as test 5
	localparam int readAccesses = 8 * 64;
	localparam int writeAccesses = 8 * 64 * 9;
	localparam int conflictAccesses = 18;
	localparam int mixAccesses = 300;
	localparam int cycleLimit = (2 * (readAccesses + writeAccesses + conflictAccesses)
		+ mixAccesses) * 40 + (1 << tileIdxBits);

	logic clk = 1'b0;
	logic resetAct;
	memTilePkg::memReq_t req;
	logic extNotReady;
	logic [31:0] extRdData;
	logic [63:0] rdValue;
	logic extHold;
	memTilePkg::extBus_t ext;

	integer seed;
	int testNum;
	int cycleCount;
	int errorCount;
	int checkCount;
	logic runDone;
	logic stallOn;
	logic stallNext;

	// external memory, keyed by word byte address
	logic [31:0] extMem [logic [47:0]];
	// word at the current bus address
	logic [31:0] memWord;

	memTileCache #(.tileIdxBits(tileIdxBits)) u_memTileCache (
		.clk        (clk),
		.resetAct   (resetAct),
		.req        (req),
		.extNotReady(extNotReady),
		.extRdData  (extRdData),
		.rdValue    (rdValue),
		.extHold    (extHold),
		.ext        (ext)
	);

	memTileChecker #(.tileIdxBits(tileIdxBits)) u_checker (
		.clk        (clk),
		.resetAct   (resetAct),
		.req        (req),
		.rdValue    (rdValue),
		.extHold    (extHold),
		.ext        (ext),
		.extNotReady(extNotReady),
		.testNum    (testNum),
		.runDone    (runDone),
		.errorCount (errorCount),
		.checkCount (checkCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory model, store beat first then the read for the next edge
	always @(negedge clk)
	begin
		if (ext.wr && !extNotReady)
			extMem[ext.addr] = ext.wrData;
		if (extMem.exists(ext.addr))
			memWord = extMem[ext.addr];
		else
			for (int i = 0; i < 4; i++)
				memWord[8*i +: 8] = fillByte(ext.addr + 48'(i));
		// garbage unless a load beat is on the bus
		extRdData = ext.oe ? memWord : ~memWord;
		// roughly one stall in four
		stallNext = stallOn && (($random(seed) & 3) == 0);
	end

	always @(posedge clk)
		#1 extNotReady = stallNext;

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout: no finish within %0d cycles", cycleLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// power-up byte, every address bit folded in
	function automatic logic [7:0] fillByte(logic [47:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40] ^ 8'h5A;
	endfunction

	// natural alignment of a mode, none and oword as qword
	function automatic int sizeOf(int mode);
		case (mode)
			1, 6: return 1;
			2, 7: return 2;
			3: return 4;
			default: return 8;
		endcase
	endfunction

	// called just after a rising edge, returns just after the completing edge
	task automatic doAccess(input logic rd, input logic wr, input int mode,
		input logic [47:0] addr, input logic [63:0] value);
		req.rd = rd;
		req.wr = wr;
		req.mode = memTilePkg::accessMode_t'(mode[2:0]);
		req.addr = addr;
		req.wrValue = value;
		@(negedge clk);
		while (extHold)
			@(negedge clk);
		@(posedge clk);
		#1;
		req.rd = 1'b0;
		req.wr = 1'b0;
	endtask

	// first read misses, the rest hit
	task automatic readModes(input logic [47:0] base);
		for (int off = 0; off < 64; off++)
			for (int m = 0; m < 8; m++)
				if (off % sizeOf(m) == 0)
					doAccess(1'b1, 1'b0, m, base + 48'(off), 64'd0);
	endtask

	task automatic writeSizes(input logic [47:0] base);
		logic [63:0] value;
		for (int m = 0; m < 8; m++)
			for (int off = 0; off < 64; off += sizeOf(m))
			begin
				value = {$random(seed), $random(seed)};
				doAccess(1'b0, 1'b1, m, base + 48'(off), value);
				for (int r = 0; r < 8; r++)
					if (off % sizeOf(r) == 0)
						doAccess(1'b1, 1'b0, r, base + 48'(off), 64'd0);
			end
	endtask

	task automatic writeBack(input logic [47:0] base);
		for (int k = 0; k < 8; k++)
			doAccess(1'b0, 1'b1, 4, base + 48'(8 * k), {$random(seed), $random(seed)});
		// conflicting tag evicts the dirty tile
		doAccess(1'b0, 1'b1, 3, base + tagStride + 48'd20, {$random(seed), $random(seed)});
		for (int k = 0; k < 8; k++)
			doAccess(1'b1, 1'b0, 4, base + 48'(8 * k), 64'd0);
		// conflicting tile again, refilled from its own write-back
		doAccess(1'b1, 1'b0, 3, base + tagStride + 48'd20, 64'd0);
	endtask

	// four tags on one index
	task automatic randomMix(input logic [47:0] base, input int count);
		int mode;
		int off;
		logic isWrite;
		logic [47:0] addr;
		for (int n = 0; n < count; n++)
		begin
			mode = $random(seed) & 7;
			off = ($random(seed) & 63) & ~(sizeOf(mode) - 1);
			isWrite = (($random(seed) & 1) == 1);
			addr = base + tagStride * 48'($random(seed) & 3) + 48'(off);
			doAccess(!isWrite, isWrite, mode, addr, {$random(seed), $random(seed)});
		end
	endtask

	initial
	begin
		seed = 56888;
		resetAct = 1'b1;
		req = '0;
		extNotReady = 1'b0;
		extRdData = '0;
		stallOn = 1'b0;
		stallNext = 1'b0;
		runDone = 1'b0;
		testNum = 1;
		cycleCount = 0;
		repeat (3) @(posedge clk);
		#1;
		resetAct = 1'b0;
		// sweep keeps extHold up
		@(negedge clk);
		while (extHold)
			@(negedge clk);
		@(posedge clk);
		#1;
		testNum = 2;
		readModes(48'h1234_5600_0000 + 48'd3 * 48'd64);
		testNum = 3;
		writeSizes(48'h1234_5600_0000 + 48'd5 * 48'd64);
		testNum = 4;
		writeBack(48'h1234_5600_0000 + 48'd9 * 48'd64);
		// same tests on fresh tiles with a stalling bus
		testNum = 5;
		stallOn = 1'b1;
		readModes(48'h0BAD_0000_0000 + 48'd20 * 48'd64);
		writeSizes(48'h0BAD_0000_0000 + 48'd21 * 48'd64);
		writeBack(48'h0BAD_0000_0000 + 48'd22 * 48'd64);
		testNum = 6;
		randomMix(48'hA5A5_0000_0000 + 48'd40 * 48'd64, mixAccesses);
		runDone = 1'b1;
		@(negedge clk);
		#1;
		if (checkCount == 0)
			$display("no comparisons were made during the run");
		if (errorCount == 0 && checkCount > 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: dv/memTileChecker.sv
`timescale 1ns/1ps

module memTileChecker #(
	parameter int tileIdxBits = 7
) (
	input  logic clk,
	input  logic resetAct,
	input  memTilePkg::memReq_t req,
	input  logic [63:0] rdValue,
	input  logic extHold,
	input  memTilePkg::extBus_t ext,
	input  logic extNotReady,
	input  int testNum,
	input  logic runDone,
	output int errorCount,
	output int checkCount
);

	// every byte the core has stored so far
	logic [7:0] shadow [logic [47:0]];

	int lastTest;
	int testErrors;
	int testChecks;
	int sweepCycles;
	logic inSweep;
	logic summaryDone;
	logic [63:0] expected;

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		lastTest = 0;
		testErrors = 0;
		testChecks = 0;
		sweepCycles = 0;
		inSweep = 1'b0;
		summaryDone = 1'b0;
	end

	// stored byte, else the power-up pattern
	function automatic logic [7:0] memByte(logic [47:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40] ^ 8'h5A;
	endfunction

	// expected load, eight bytes little endian then cut to size
	function automatic logic [63:0] refLoad(logic [47:0] a, memTilePkg::accessMode_t mode);
		logic [63:0] bytes;
		for (int i = 0; i < 8; i++)
			bytes[8*i +: 8] = memByte(a + 48'(i));
		case (mode)
			memTilePkg::modeByte:  return {{56{bytes[7]}}, bytes[7:0]};
			memTilePkg::modeWord:  return {{48{bytes[15]}}, bytes[15:0]};
			memTilePkg::modeDword: return {{32{bytes[31]}}, bytes[31:0]};
			memTilePkg::modeUbyte: return {56'd0, bytes[7:0]};
			memTilePkg::modeUword: return {48'd0, bytes[15:0]};
			default:               return bytes;
		endcase
	endfunction

	// bytes written by a store of this mode
	function automatic int storeBytes(memTilePkg::accessMode_t mode);
		case (mode)
			memTilePkg::modeByte, memTilePkg::modeUbyte: return 1;
			memTilePkg::modeWord, memTilePkg::modeUword: return 2;
			memTilePkg::modeDword: return 4;
			memTilePkg::modeQword: return 8;
			default: return 0;
		endcase
	endfunction

	task automatic compare(string name, logic [63:0] exp, logic [63:0] act);
		checkCount++;
		testChecks++;
		if (exp !== act)
		begin
			errorCount++;
			testErrors++;
			$display("ERROR time %0t signal %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic reportTest(int num);
		$display("test %0d %s: %0d checks, %0d errors", num,
			(testErrors == 0) ? "ok" : "failed", testChecks, testErrors);
		testErrors = 0;
		testChecks = 0;
	endtask

	// sampled at negedge, values hold until the next rising edge
	always @(negedge clk)
	begin
		if (testNum != lastTest)
		begin
			if (lastTest != 0)
				reportTest(lastTest);
			lastTest = testNum;
		end
		// bus quiet through reset and sweep
		if (resetAct || inSweep)
		begin
			compare("ext.oe", 64'd0, {63'd0, ext.oe});
			compare("ext.wr", 64'd0, {63'd0, ext.wr});
		end
		if (resetAct)
		begin
			inSweep = 1'b1;
			sweepCycles = 0;
		end
		else if (inSweep)
		begin
			if (extHold)
				sweepCycles++;
			else
			begin
				// one tile invalidated per cycle
				inSweep = 1'b0;
				compare("sweep cycles", 64'(1 << tileIdxBits), 64'(sweepCycles));
			end
		end
		else
		begin
			// read completes at the coming edge
			if (req.rd && !extHold)
				compare("rdValue", refLoad(req.addr, req.mode), rdValue);
			// write-back beat taken at the coming edge
			if (ext.wr && !extNotReady)
			begin
				expected = refLoad(ext.addr, memTilePkg::modeQword);
				compare("ext.wrData", {32'd0, expected[31:0]}, {32'd0, ext.wrData});
			end
			if (req.wr && !extHold)
				for (int i = 0; i < storeBytes(req.mode); i++)
					shadow[req.addr + 48'(i)] = req.wrValue[8*i +: 8];
		end
		if (runDone && !summaryDone)
		begin
			summaryDone = 1'b1;
			reportTest(lastTest);
			$display("summary: %0d checks, %0d errors", checkCount, errorCount);
		end
	end

endmodule

// File: memTileCache.f
rtl/memTilePkg.sv
rtl/tileTagStore.sv
rtl/tileDataStore.sv
rtl/accessAlign.sv
rtl/tileRefillEngine.sv
rtl/memTileCache.sv
dv/memTileChecker.sv
dv/memTileCacheTb.sv

// File: rtl/accessAlign.sv
`timescale 1ns/1ps

module accessAlign (
	input  logic [63:0] window,
	input  memTilePkg::accessMode_t mode,
	input  logic [1:0] byteOff,
	input  logic [63:0] wrValue,
	output logic [63:0] loadValue,
	output logic [63:0] mergedWindow
);

	// bit shift for the byte offset, at most 24
	logic [4:0] shiftAmt;

	// window with the addressed byte at bit 0
	logic [63:0] shifted;

	// bytes touched by a store, before shifting
	logic [63:0] storeMask;

	assign shiftAmt = {byteOff, 3'b000};
	assign shifted = window >> shiftAmt;

	// load select and extend
	always_comb
	begin
		case (mode)
			memTilePkg::modeByte:
				loadValue = {{56{shifted[7]}}, shifted[7:0]};
			memTilePkg::modeWord:
				loadValue = {{48{shifted[15]}}, shifted[15:0]};
			memTilePkg::modeDword:
				loadValue = {{32{shifted[31]}}, shifted[31:0]};
			memTilePkg::modeUbyte:
				loadValue = {56'd0, shifted[7:0]};
			memTilePkg::modeUword:
				loadValue = {48'd0, shifted[15:0]};
			// qword, oword and none
			default:
				loadValue = shifted;
		endcase
	end

	// store size by mode
	// unsigned modes store the same width as their signed pair
	always_comb
	begin
		case (mode)
			memTilePkg::modeByte,
			memTilePkg::modeUbyte:
				storeMask = 64'h0000_0000_0000_00FF;
			memTilePkg::modeWord,
			memTilePkg::modeUword:
				storeMask = 64'h0000_0000_0000_FFFF;
			memTilePkg::modeDword:
				storeMask = 64'h0000_0000_FFFF_FFFF;
			memTilePkg::modeQword:
				storeMask = 64'hFFFF_FFFF_FFFF_FFFF;
			// oword and none leave the window alone
			default:
				storeMask = 64'd0;
		endcase
	end

	// overlay store bytes at the offset
	// aligned accesses never spill past bit 63
	assign mergedWindow = (window & ~(storeMask << shiftAmt))
		| ((wrValue & storeMask) << shiftAmt);

endmodule

// File: rtl/memTileCache.sv
`timescale 1ns/1ps

module memTileCache #(
	parameter int tileIdxBits = 7
) (
	input  logic clk,
	input  logic resetAct,
	input  memTilePkg::memReq_t req,
	input  logic extNotReady,
	input  logic [memTilePkg::wordBits-1:0] extRdData,
	output logic [63:0] rdValue,
	output logic extHold,
	output memTilePkg::extBus_t ext
);

	// lookup results
	logic hit;
	logic victimDirty;
	logic [memTilePkg::addrBits-1:0] victimBase;
	logic sweepBusy;

	// engine control
	logic access;
	logic grant;
	logic install;
	logic [memTilePkg::addrBits-1:0] missBase;

	// burst port
	logic [memTilePkg::wordIdxBits-1:0] burstWordIdx;
	logic burstWe;
	logic [memTilePkg::wordBits-1:0] burstData;
	logic [memTilePkg::wordBits-1:0] burstRdData;

	// hit path window, before and after store merge
	logic [63:0] window;
	logic [63:0] mergedWindow;

	assign access = req.rd || req.wr;
	assign missBase = {req.addr[memTilePkg::addrBits-1:memTilePkg::tileOffBits],
		{memTilePkg::tileOffBits{1'b0}}};

	tileTagStore #(.tileIdxBits(tileIdxBits)) u_tagStore (
		.clk        (clk),
		.resetAct   (resetAct),
		.addr       (req.addr),
		.wr         (req.wr),
		.grant      (grant),
		.install    (install),
		.hit        (hit),
		.victimDirty(victimDirty),
		.victimBase (victimBase),
		.sweepBusy  (sweepBusy)
	);

	tileDataStore #(.tileIdxBits(tileIdxBits)) u_dataStore (
		.clk         (clk),
		.addr        (req.addr),
		.wr          (req.wr),
		.grant       (grant),
		.burstWordIdx(burstWordIdx),
		.burstWe     (burstWe),
		.burstData   (burstData),
		.mergedWindow(mergedWindow),
		.window      (window),
		.burstRdData (burstRdData)
	);

	// byte offset is the low address bits
	accessAlign u_accessAlign (
		.window      (window),
		.mode        (req.mode),
		.byteOff     (req.addr[1:0]),
		.wrValue     (req.wrValue),
		.loadValue   (rdValue),
		.mergedWindow(mergedWindow)
	);

	tileRefillEngine #(.tileIdxBits(tileIdxBits)) u_refillEngine (
		.clk         (clk),
		.resetAct    (resetAct),
		.access      (access),
		.hit         (hit),
		.victimDirty (victimDirty),
		.victimBase  (victimBase),
		.missBase    (missBase),
		.sweepBusy   (sweepBusy),
		.extNotReady (extNotReady),
		.extRdData   (extRdData),
		.burstRdData (burstRdData),
		.ext         (ext),
		.burstWordIdx(burstWordIdx),
		.burstWe     (burstWe),
		.burstData   (burstData),
		.install     (install),
		.grant       (grant),
		.extHold     (extHold)
	);

endmodule

// File: rtl/memTilePkg.sv
package memTilePkg;

	// physical address width, shared by core and external bus
	localparam int addrBits = 48;

	// one external beat, one tile word
	localparam int wordBits = 32;

	// tile geometry, 16 words of 4 bytes
	localparam int wordsPerTile = 16;
	localparam int wordIdxBits = 4;
	localparam int tileOffBits = 6;

	// access size and extension, encoding kept from the core
	// oword and none load a full qword and store nothing
	typedef enum logic [2:0]
	{
		modeNone  = 3'b000,
		modeByte  = 3'b001,
		modeWord  = 3'b010,
		modeDword = 3'b011,
		modeQword = 3'b100,
		modeOword = 3'b101,
		modeUbyte = 3'b110,
		modeUword = 3'b111
	} accessMode_t;

	// core request, held stable while extHold is high
	typedef struct packed
	{
		// load strobe
		logic rd;
		// store strobe
		logic wr;
		accessMode_t mode;
		// must be naturally aligned to the access size
		logic [addrBits-1:0] addr;
		// store data, right aligned
		logic [63:0] wrValue;
	} memReq_t;

	// outbound side of the external word bus
	typedef struct packed
	{
		// tile base plus four times the beat index
		logic [addrBits-1:0] addr;
		// load beat in progress
		logic oe;
		// store beat in progress
		logic wr;
		// write-back data for the current beat
		logic [wordBits-1:0] wrData;
	} extBus_t;

endpackage

// File: rtl/tileDataStore.sv
`timescale 1ns/1ps

module tileDataStore #(
	parameter int tileIdxBits = 7
) (
	input  logic clk,
	input  logic [memTilePkg::addrBits-1:0] addr,
	input  logic wr,
	input  logic grant,
	input  logic [memTilePkg::wordIdxBits-1:0] burstWordIdx,
	input  logic burstWe,
	input  logic [memTilePkg::wordBits-1:0] burstData,
	input  logic [63:0] mergedWindow,
	output logic [63:0] window,
	output logic [memTilePkg::wordBits-1:0] burstRdData
);

	localparam int wordAddrBits = tileIdxBits + memTilePkg::wordIdxBits;
	localparam int wordCount = 1 << wordAddrBits;
	// byte lane bits below the word index
	localparam int laneBits = memTilePkg::tileOffBits - memTilePkg::wordIdxBits;

	// all tiles, word addressed as {tile, word}
	logic [memTilePkg::wordBits-1:0] tileWords [wordCount];

	logic [tileIdxBits-1:0] tileIdx;
	logic [memTilePkg::wordIdxBits-1:0] wordIdx;
	logic [memTilePkg::wordIdxBits-1:0] nextWordIdx;
	logic [wordAddrBits-1:0] loAddr;
	logic [wordAddrBits-1:0] hiAddr;
	logic [wordAddrBits-1:0] burstAddr;

	assign tileIdx = addr[memTilePkg::tileOffBits +: tileIdxBits];
	assign wordIdx = addr[laneBits +: memTilePkg::wordIdxBits];

	// second word wraps inside the tile
	assign nextWordIdx = wordIdx + 1'b1;

	assign loAddr = {tileIdx, wordIdx};
	assign hiAddr = {tileIdx, nextWordIdx};

	// burst always targets the requested tile slot
	assign burstAddr = {tileIdx, burstWordIdx};

	// two-word access window, addressed word in the low half
	assign window = {tileWords[hiAddr], tileWords[loAddr]};

	// write-back source
	assign burstRdData = tileWords[burstAddr];

	// store commit or refill beat, never both in one cycle
	always_ff @(posedge clk)
	begin
		if (grant && wr)
		begin
			tileWords[loAddr] <= mergedWindow[31:0];
			tileWords[hiAddr] <= mergedWindow[63:32];
		end
		else if (burstWe)
			tileWords[burstAddr] <= burstData;
	end

endmodule

// File: rtl/tileRefillEngine.sv
`timescale 1ns/1ps

module tileRefillEngine #(
	parameter int tileIdxBits = 7
) (
	input  logic clk,
	input  logic resetAct,
	input  logic access,
	input  logic hit,
	input  logic victimDirty,
	input  logic [memTilePkg::addrBits-1:0] victimBase,
	input  logic [memTilePkg::addrBits-1:0] missBase,
	input  logic sweepBusy,
	input  logic extNotReady,
	input  logic [memTilePkg::wordBits-1:0] extRdData,
	input  logic [memTilePkg::wordBits-1:0] burstRdData,
	output memTilePkg::extBus_t ext,
	output logic [memTilePkg::wordIdxBits-1:0] burstWordIdx,
	output logic burstWe,
	output logic [memTilePkg::wordBits-1:0] burstData,
	output logic install,
	output logic grant,
	output logic extHold
);

	localparam int tagBits = memTilePkg::addrBits - memTilePkg::tileOffBits - tileIdxBits;

	typedef enum logic [1:0]
	{
		stateIdle,
		stateStoreBurst,
		stateLoadBurst,
		stateInstall
	} engineState_t;

	engineState_t state;

	// word index of the current beat
	logic [memTilePkg::wordIdxBits-1:0] beatIdx;

	// tag of the tile on the bus, victim first then miss
	logic [tagBits-1:0] burstTag;

	// victim and miss share the same index
	logic [tileIdxBits-1:0] tileIdx;

	logic missStart;
	logic beatTaken;
	logic lastBeat;

	assign tileIdx = missBase[memTilePkg::tileOffBits +: tileIdxBits];

	// no refills while tags are being cleared
	assign missStart = access && !hit && !sweepBusy;

	// a beat moves when the bus is active and not stalled
	assign beatTaken = ((state == stateStoreBurst) || (state == stateLoadBurst))
		&& !extNotReady;
	assign lastBeat = (beatIdx == {memTilePkg::wordIdxBits{1'b1}});

	always_ff @(posedge clk)
	begin
		if (resetAct)
		begin
			state <= stateIdle;
			beatIdx <= '0;
		end
		else
		begin
			// wraps back to 0 after the last beat
			if (beatTaken)
				beatIdx <= beatIdx + 1'b1;

			case (state)
				stateIdle:
					if (missStart)
						state <= victimDirty ? stateStoreBurst : stateLoadBurst;
				stateStoreBurst:
					if (beatTaken && lastBeat)
						state <= stateLoadBurst;
				stateLoadBurst:
					if (beatTaken && lastBeat)
						state <= stateInstall;
				default:
					state <= stateIdle;
			endcase
		end
	end

	// bus tag, swapped to the miss tile between bursts
	always_ff @(posedge clk)
	begin
		if ((state == stateIdle) && missStart)
		begin
			if (victimDirty)
				burstTag <= victimBase[memTilePkg::addrBits-1 -: tagBits];
			else
				burstTag <= missBase[memTilePkg::addrBits-1 -: tagBits];
		end
		else if ((state == stateStoreBurst) && beatTaken && lastBeat)
			burstTag <= missBase[memTilePkg::addrBits-1 -: tagBits];
	end

	// outbound bus, held steady through extNotReady
	always_comb
	begin
		ext.addr = {burstTag, tileIdx, beatIdx, 2'b00};
		ext.oe = (state == stateLoadBurst);
		ext.wr = (state == stateStoreBurst);
		ext.wrData = burstRdData;
	end

	// refill port into the data store
	assign burstWordIdx = beatIdx;
	assign burstWe = (state == stateLoadBurst) && !extNotReady;
	assign burstData = extRdData;

	// tag write one cycle after the final load beat
	assign install = (state == stateInstall);

	// hit path only runs with the engine quiet
	assign grant = access && hit && (state == stateIdle);

	// stall on sweep, on a fresh miss, and for the whole refill
	assign extHold = sweepBusy || missStart || (state != stateIdle);

endmodule

// File: rtl/tileTagStore.sv
`timescale 1ns/1ps

module tileTagStore #(
	parameter int tileIdxBits = 7
) (
	input  logic clk,
	input  logic resetAct,
	input  logic [memTilePkg::addrBits-1:0] addr,
	input  logic wr,
	input  logic grant,
	input  logic install,
	output logic hit,
	output logic victimDirty,
	output logic [memTilePkg::addrBits-1:0] victimBase,
	output logic sweepBusy
);

	// tag is what is left above index and tile offset
	localparam int tagBits = memTilePkg::addrBits - memTilePkg::tileOffBits - tileIdxBits;
	localparam int tileCount = 1 << tileIdxBits;

	// per-tile tag, valid and dirty
	logic [tagBits-1:0] tagMem [tileCount];
	logic [tileCount-1:0] validBits;
	logic [tileCount-1:0] dirtyBits;

	// lookup fields of the request address
	logic [tileIdxBits-1:0] tileIdx;
	logic [tagBits-1:0] addrTag;

	// invalidate pointer after reset
	logic [tileIdxBits-1:0] sweepIdx;

	assign tileIdx = addr[memTilePkg::tileOffBits +: tileIdxBits];
	assign addrTag = addr[memTilePkg::addrBits-1 -: tagBits];

	// no hits until every tile has been invalidated
	assign hit = validBits[tileIdx] && (tagMem[tileIdx] == addrTag) && !sweepBusy;

	// only a valid tile needs writing back
	assign victimDirty = validBits[tileIdx] && dirtyBits[tileIdx];

	// resident tile base, same index as the request
	assign victimBase = {tagMem[tileIdx], tileIdx, {memTilePkg::tileOffBits{1'b0}}};

	// valid and dirty, with the post-reset sweep
	always_ff @(posedge clk)
	begin
		if (resetAct)
		begin
			sweepBusy <= 1'b1;
			sweepIdx <= '0;
		end
		else if (sweepBusy)
		begin
			// one tile per cycle
			validBits[sweepIdx] <= 1'b0;
			dirtyBits[sweepIdx] <= 1'b0;
			sweepIdx <= sweepIdx + 1'b1;
			if (sweepIdx == {tileIdxBits{1'b1}})
				sweepBusy <= 1'b0;
		end
		else if (install)
		begin
			// freshly loaded tile matches memory
			validBits[tileIdx] <= 1'b1;
			dirtyBits[tileIdx] <= 1'b0;
		end
		else if (grant && wr)
			dirtyBits[tileIdx] <= 1'b1;
	end

	// tag array
	always_ff @(posedge clk)
	begin
		if (install)
			tagMem[tileIdx] <= addrTag;
	end

endmodule
